// ==== verif/program_stimulus.hex ====
// one 32-bit hex word per entry, pairs are (address data)
// 0x00 header: initial pc, success code, program words, data pairs, expected stores
@00
00000100 000005A5 00000018 00000003 00000006
// 0x10 program words from the initial pc on
@10
00002083 // lw   x1, 0(x0)
00500113 // addi x2, x0, 5
00710193 // addi x3, x2, 7
00218233 // add  x4, x3, x2
403202B3 // sub  x5, x4, x3
02402023 // sw   x4, 0x20(x0)
02502223 // sw   x5, 0x24(x0)
00402303 // lw   x6, 4(x0)
00130393 // addi x7, x6, 1
00638433 // add  x8, x7, x6
02802423 // sw   x8, 0x28(x0)
02602623 // sw   x6, 0x2c(x0)
00228663 // beq  x5, x2, +12
02202823 // sw   x2, 0x30(x0)  skipped
02302A23 // sw   x3, 0x34(x0)  skipped
00802483 // lw   x9, 8(x0)
40848533 // sub  x10, x9, x8
02A02823 // sw   x10, 0x30(x0)
FFF00593 // addi x11, x0, -1
00858633 // add  x12, x11, x8
02C02A23 // sw   x12, 0x34(x0)
5A500693 // addi x13, x0, 0x5a5
00D0A023 // sw   x13, 0(x1)  success store
00000063 // beq  x0, x0, 0
// 0x30 initial data words
@30
00000000 80000000
00000004 00000123
00000008 00001000
// 0x40 expected data-port stores in order
@40
00000020 00000011
00000024 00000005
00000028 00000247
0000002C 00000123
00000030 00000DB9
00000034 00000246

// ==== sim.f ====
hdl/rv_core_pkg.sv
hdl/run_control.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/mem_access.sv
hdl/rv32_pipeline_top.sv
verif/rv32_pipeline_asserts.sv
verif/tb_rv32_pipeline.sv

// ==== Bender.yml ====
package:
  name: rv32_pipeline

sources:
  - files:
      - hdl/rv_core_pkg.sv
      - hdl/run_control.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/reg_file.sv
      - hdl/execute_stage.sv
      - hdl/mem_access.sv
      - hdl/rv32_pipeline_top.sv
  - target: test
    files:
      - verif/rv32_pipeline_asserts.sv
      - verif/tb_rv32_pipeline.sv

// ==== verif/tb_rv32_pipeline.sv ====
module tb_rv32_pipeline import rv_core_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   logic     clk;
   logic     reset;
   logic     start;
   word_t    initial_pc;
   word_t    success_code;
   word_t    imem_addr;
   word_t    imem_data;
   mem_req_t dmem_req;
   mem_rsp_t dmem_rsp;
   mem_req_t preq;
   mem_rsp_t prsp;
   logic     stop;
   word_t    cycle_count;

   word_t       stim [128];
   word_t       rom [256];
   word_t       ram [64];
   word_t       n_store;
   int          store_idx;
   int unsigned dmem_delay [64];
   int unsigned pmem_delay [8];
   int unsigned dmem_wait;
   int unsigned dmem_done;
   int unsigned pmem_wait;
   int unsigned pmem_done;
   logic        success_seen;
   word_t       success_count;

   rv32_pipeline_top u_rv32_pipeline_top (
      .clk            (clk),
      .reset          (reset),
      .start_i        (start),
      .initial_pc_i   (initial_pc),
      .success_code_i (success_code),
      .imem_addr_o    (imem_addr),
      .imem_data_i    (imem_data),
      .dmem_req_o     (dmem_req),
      .dmem_rsp_i     (dmem_rsp),
      .preq_o         (preq),
      .prsp_i         (prsp),
      .stop_o         (stop),
      .cycle_count_o  (cycle_count)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic finish_failed();
      $display("=== FAIL ===");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic fail_plain(input string what);
      $display("%0t ns: %s", $time, what);
      finish_failed();
   endtask

   task automatic check_store(input string name, input mem_req_t got, input mem_req_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t ns %s: got addr=%h wdata=%h we=%b, expected addr=%h wdata=%h we=%b",
                  $time, name, got.addr, got.wdata, got.we, exp.addr, exp.wdata, exp.we);
         finish_failed();
      end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
         finish_failed();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
         finish_failed();
      end
   endtask

   // header at 0x00, program at 0x10, data pairs at 0x30, expected stores at 0x40
   task automatic load_stimulus();
      int base;
      $readmemh("verif/program_stimulus.hex", stim);
      if ($isunknown(stim[0]) || $isunknown(stim[4])) begin
         fail_plain("stimulus file is missing or has no header");
      end
      // unused rom words are addi x0, x0, index
      for (int i = 0; i < 256; i++) begin
         rom[i] = NOP_INSN | word_t'(i << 20);
      end
      // uninitialized ram words carry their own address
      for (int i = 0; i < 64; i++) begin
         ram[i] = 32'hD0D0_0000 | word_t'(i << 2);
      end
      base = int'(stim[0][9:2]);
      for (int i = 0; i < int'(stim[2]); i++) begin
         rom[base + i] = stim['h10 + i];
      end
      for (int i = 0; i < int'(stim[3]); i++) begin
         ram[stim['h30 + 2 * i][7:2]] = stim['h31 + 2 * i];
      end
   endtask

   task automatic record_store(input mem_req_t got);
      mem_req_t exp;
      if (word_t'(store_idx) >= n_store) begin
         fail_plain($sformatf("data store to %h is not in the expected list", got.addr));
      end
      exp = '{req: 1'b1, we: 1'b1,
              addr: stim['h40 + 2 * store_idx], wdata: stim['h41 + 2 * store_idx]};
      check_store("dmem_req_o", got, exp);
      ram[got.addr[7:2]] = got.wdata;
      store_idx++;
   endtask

   // instruction rom answers in the same cycle
   always_comb begin
      if (imem_addr[31:10] == '0) begin
         imem_data = rom[imem_addr[9:2]];
      end else begin
         imem_data = NOP_INSN;
      end
   end

   // data ram, grant after a random wait
   always @(posedge clk) begin
      if (reset) begin
         dmem_rsp  <= '0;
         dmem_wait <= dmem_delay[0];
         dmem_done <= 0;
      end else if (dmem_rsp.gnt) begin
         if (dmem_req.we) begin
            record_store(dmem_req);
         end
         dmem_done <= dmem_done + 1;
         dmem_wait <= dmem_delay[(dmem_done + 1) % 64];
         dmem_rsp  <= '0;
      end else if (dmem_req.req) begin
         if (dmem_req.addr[31:8] != '0) begin
            fail_plain($sformatf("data access to %h is outside the modeled ram", dmem_req.addr));
         end
         if (dmem_wait == 0) begin
            dmem_rsp.gnt   <= 1'b1;
            dmem_rsp.rdata <= dmem_req.we ? '0 : ram[dmem_req.addr[7:2]];
         end else begin
            dmem_wait <= dmem_wait - 1;
         end
      end
   end

   // peripheral, only the success store is expected here
   always @(posedge clk) begin
      if (reset) begin
         prsp      <= '0;
         pmem_wait <= pmem_delay[0];
         pmem_done <= 0;
      end else if (prsp.gnt) begin
         if (!preq.we) begin
            fail_plain($sformatf("unexpected peripheral read from %h", preq.addr));
         end
         check_store("preq_o", preq,
                     '{req: 1'b1, we: 1'b1, addr: PERIPH_BASE, wdata: success_code});
         check_word("data stores before success", word_t'(store_idx), n_store);
         success_seen  <= 1'b1;
         success_count <= cycle_count;
         pmem_done     <= pmem_done + 1;
         pmem_wait     <= pmem_delay[(pmem_done + 1) % 8];
         prsp          <= '0;
      end else if (preq.req) begin
         if (pmem_wait == 0) begin
            prsp.gnt <= 1'b1;
         end else begin
            pmem_wait <= pmem_wait - 1;
         end
      end
   end

   always @(posedge clk) begin
      if (u_rv32_pipeline_top.u_rv32_pipeline_asserts.fail_count != 0) begin
         fail_plain("a bound assertion on the DUT failed");
      end
   end

   initial begin
      int unsigned waited;
      word_t       frozen;
      void'($urandom(35932));
      for (int i = 0; i < 64; i++) begin
         dmem_delay[i] = $urandom % 4;
      end
      for (int i = 0; i < 8; i++) begin
         pmem_delay[i] = $urandom % 4;
      end
      reset        = 1'b1;
      start        = 1'b0;
      dmem_rsp     = '0;
      prsp         = '0;
      store_idx    = 0;
      success_seen = 1'b0;
      load_stimulus();
      initial_pc   = stim[0];
      success_code = stim[1];
      n_store      = stim[4];

      repeat (8) @(posedge clk);
      reset <= 1'b0;

      // idle after reset
      @(posedge clk);
      check_flag("stop_o", stop, 1'b0);
      check_flag("dmem_req_o.req", dmem_req.req, 1'b0);
      check_flag("preq_o.req", preq.req, 1'b0);
      check_word("cycle_count_o", cycle_count, '0);

      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;

      // pc took the start address on the start edge
      @(posedge clk);
      check_word("imem_addr_o", imem_addr, initial_pc);

      waited = 0;
      while (!success_seen) begin
         @(posedge clk);
         waited++;
         if (waited > 3000) begin
            fail_plain("no success store reached the peripheral port");
         end
      end

      waited = 0;
      while (stop !== 1'b1) begin
         @(posedge clk);
         waited++;
         if (waited > DRAIN_CYCLES + 10) begin
            fail_plain("stop_o did not rise after the drain");
         end
      end
      // one count for the success cycle, then the drain
      check_word("cycle_count_o", cycle_count, success_count + DRAIN_CYCLES + 1);

      frozen = cycle_count;
      repeat (20) begin
         @(posedge clk);
         check_word("cycle_count_o", cycle_count, frozen);
         check_flag("stop_o", stop, 1'b1);
         check_flag("dmem_req_o.req", dmem_req.req, 1'b0);
         check_flag("preq_o.req", preq.req, 1'b0);
      end

      if (u_rv32_pipeline_top.u_rv32_pipeline_asserts.fail_count == 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         fail_plain("bound assertions reported failures");
      end
   end

endmodule

// ==== verif/rv32_pipeline_asserts.sv ====
module rv32_pipeline_asserts import rv_core_pkg::*; (
   input logic     clk,
   input logic     reset,
   input mem_req_t dmem_req_i,
   input mem_rsp_t dmem_rsp_i,
   input mem_req_t preq_i,
   input mem_rsp_t prsp_i,
   input logic     stop_i
);

   timeunit 1ns;
   timeprecision 1ps;

   int unsigned fail_count = 0;

   one_port_at_a_time: assert property (@(posedge clk) disable iff (reset)
      !(dmem_req_i.req && preq_i.req))
      else begin
         fail_count++;
         $error("data and peripheral requests are high together");
      end

   // pending request frozen until granted
   dmem_req_held: assert property (@(posedge clk) disable iff (reset)
      dmem_req_i.req && !dmem_rsp_i.gnt |=> dmem_req_i.req && $stable(dmem_req_i))
      else begin
         fail_count++;
         $error("data request changed before grant");
      end

   preq_held: assert property (@(posedge clk) disable iff (reset)
      preq_i.req && !prsp_i.gnt |=> preq_i.req && $stable(preq_i))
      else begin
         fail_count++;
         $error("peripheral request changed before grant");
      end

   stop_sticky: assert property (@(posedge clk) disable iff (reset)
      stop_i |=> stop_i)
      else begin
         fail_count++;
         $error("stop_o fell without reset");
      end

endmodule

bind rv32_pipeline_top rv32_pipeline_asserts u_rv32_pipeline_asserts (
   .clk        (clk),
   .reset      (reset),
   .dmem_req_i (dmem_req_o),
   .dmem_rsp_i (dmem_rsp_i),
   .preq_i     (preq_o),
   .prsp_i     (prsp_i),
   .stop_i     (stop_o)
);

// ==== hdl/rv32_pipeline_top.sv ====
module rv32_pipeline_top import rv_core_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     start_i,
   input  word_t    initial_pc_i,
   input  word_t    success_code_i,
   output word_t    imem_addr_o,
   input  word_t    imem_data_i,
   output mem_req_t dmem_req_o,
   input  mem_rsp_t dmem_rsp_i,
   output mem_req_t preq_o,
   input  mem_rsp_t prsp_i,
   output logic     stop_o,
   output word_t    cycle_count_o
);

   logic      advance;
   logic      enable;
   logic      redirect_taken;
   word_t     redirect_target;
   if_id_t    if_id;
   id_ex_t    id_ex;
   ex_mem_t   ex_mem;
   mem_wb_t   mem_wb;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   word_t     rs1_val;
   word_t     rs2_val;
   fwd_t      mem_fwd;
   fwd_t      wb_fwd;

   // writeback register seen as a forwarding source
   assign wb_fwd = '{valid: mem_wb.valid && mem_wb.we, rd: mem_wb.rd, value: mem_wb.result};

   run_control u_run_control (
      .clk            (clk),
      .reset          (reset),
      .start_i        (start_i),
      .success_code_i (success_code_i),
      .periph_write_i (preq_o),
      .periph_gnt_i   (prsp_i.gnt),
      .enable_o       (enable),
      .stop_o         (stop_o),
      .cycle_count_o  (cycle_count_o)
   );

   fetch_stage u_fetch_stage (
      .clk               (clk),
      .reset             (reset),
      .start_i           (start_i),
      .initial_pc_i      (initial_pc_i),
      .advance_i         (advance),
      .enable_i          (enable),
      .redirect_taken_i  (redirect_taken),
      .redirect_target_i (redirect_target),
      .imem_addr_o       (imem_addr_o),
      .imem_data_i       (imem_data_i),
      .if_id_o           (if_id)
   );

   decode_stage u_decode_stage (
      .clk       (clk),
      .reset     (reset),
      .advance_i (advance),
      .enable_i  (enable),
      .flush_i   (redirect_taken),
      .if_id_i   (if_id),
      .rs1_o     (rs1_addr),
      .rs2_o     (rs2_addr),
      .rs1_val_i (rs1_val),
      .rs2_val_i (rs2_val),
      .id_ex_o   (id_ex)
   );

   reg_file u_reg_file (
      .clk       (clk),
      .reset     (reset),
      .rs1_i     (rs1_addr),
      .rs2_i     (rs2_addr),
      .rs1_val_o (rs1_val),
      .rs2_val_o (rs2_val),
      .wb_i      (mem_wb)
   );

   execute_stage u_execute_stage (
      .clk               (clk),
      .reset             (reset),
      .advance_i         (advance),
      .enable_i          (enable),
      .id_ex_i           (id_ex),
      .mem_fwd_i         (mem_fwd),
      .wb_fwd_i          (wb_fwd),
      .ex_mem_o          (ex_mem),
      .redirect_taken_o  (redirect_taken),
      .redirect_target_o (redirect_target)
   );

   mem_access u_mem_access (
      .clk        (clk),
      .reset      (reset),
      .enable_i   (enable),
      .ex_mem_i   (ex_mem),
      .dmem_req_o (dmem_req_o),
      .dmem_rsp_i (dmem_rsp_i),
      .preq_o     (preq_o),
      .prsp_i     (prsp_i),
      .advance_o  (advance),
      .mem_fwd_o  (mem_fwd),
      .mem_wb_o   (mem_wb)
   );

endmodule

// ==== hdl/mem_access.sv ====
module mem_access import rv_core_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     enable_i,
   input  ex_mem_t  ex_mem_i,
   output mem_req_t dmem_req_o,
   input  mem_rsp_t dmem_rsp_i,
   output mem_req_t preq_o,
   input  mem_rsp_t prsp_i,
   output logic     advance_o,
   output fwd_t     mem_fwd_o,
   output mem_wb_t  mem_wb_o
);

   logic  is_load;
   logic  is_mem;
   logic  writes_rd;
   logic  to_periph;
   logic  mem_req;
   logic  sel_gnt;
   word_t sel_rdata;
   word_t wb_value;

   assign is_load   = (ex_mem_i.op == OP_LW);
   assign is_mem    = ex_mem_i.valid && (is_load || ex_mem_i.op == OP_SW);
   assign writes_rd = ex_mem_i.valid && (ex_mem_i.rd != '0) &&
                      (ex_mem_i.op inside {OP_ADD, OP_SUB, OP_ADDI, OP_LW});
   assign to_periph = (ex_mem_i.alu_result >= PERIPH_BASE);
   // no new access once the run is disabled
   assign mem_req   = is_mem && enable_i;

   always_comb begin
      dmem_req_o.req   = mem_req && !to_periph;
      dmem_req_o.we    = (ex_mem_i.op == OP_SW);
      dmem_req_o.addr  = ex_mem_i.alu_result;
      dmem_req_o.wdata = ex_mem_i.store_data;
      preq_o           = dmem_req_o;
      preq_o.req       = mem_req && to_periph;
   end

   // response from whichever port was addressed
   assign sel_gnt   = to_periph ? prsp_i.gnt : dmem_rsp_i.gnt;
   assign sel_rdata = to_periph ? prsp_i.rdata : dmem_rsp_i.rdata;

   // whole pipeline waits here until grant
   assign advance_o = !mem_req || sel_gnt;

   assign wb_value  = is_load ? sel_rdata : ex_mem_i.alu_result;
   assign mem_fwd_o = '{valid: writes_rd, rd: ex_mem_i.rd, value: wb_value};

   always_ff @(posedge clk) begin
      if (reset) begin
         mem_wb_o.valid <= 1'b0;
         mem_wb_o.we    <= 1'b0;
      end else if (advance_o && enable_i) begin
         mem_wb_o.valid  <= ex_mem_i.valid;
         mem_wb_o.we     <= writes_rd;
         mem_wb_o.rd     <= ex_mem_i.rd;
         mem_wb_o.result <= wb_value;
      end
   end

endmodule

// ==== hdl/execute_stage.sv ====
module execute_stage import rv_core_pkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  logic    advance_i,
   input  logic    enable_i,
   input  id_ex_t  id_ex_i,
   input  fwd_t    mem_fwd_i,
   input  fwd_t    wb_fwd_i,
   output ex_mem_t ex_mem_o,
   output logic    redirect_taken_o,
   output word_t   redirect_target_o
);

   word_t rs1_fwd;
   word_t rs2_fwd;
   word_t op_b;
   word_t alu_result;
   logic  taken;

   // younger source first, MEM before WB
   function automatic word_t pick_operand(input reg_addr_t rs, input word_t reg_val,
                                          input fwd_t mem_fwd, input fwd_t wb_fwd);
      word_t val;
      val = reg_val;
      if (mem_fwd.valid && mem_fwd.rd == rs) begin
         val = mem_fwd.value;
      end else if (wb_fwd.valid && wb_fwd.rd == rs) begin
         val = wb_fwd.value;
      end
      return val;
   endfunction

   assign rs1_fwd = pick_operand(id_ex_i.rs1, id_ex_i.rs1_val, mem_fwd_i, wb_fwd_i);
   assign rs2_fwd = pick_operand(id_ex_i.rs2, id_ex_i.rs2_val, mem_fwd_i, wb_fwd_i);

   // register-register ops use rs2, the rest the immediate
   assign op_b       = (id_ex_i.op == OP_ADD || id_ex_i.op == OP_SUB) ? rs2_fwd : id_ex_i.imm;
   assign alu_result = (id_ex_i.op == OP_SUB) ? rs1_fwd - op_b : rs1_fwd + op_b;
   assign taken      = (id_ex_i.op == OP_BEQ) && (rs1_fwd == rs2_fwd);

   // branch acts from the registered decision
   assign redirect_taken_o  = ex_mem_o.valid && ex_mem_o.branch_taken;
   assign redirect_target_o = ex_mem_o.branch_target;

   always_ff @(posedge clk) begin
      if (reset) begin
         ex_mem_o.valid        <= 1'b0;
         ex_mem_o.op           <= OP_NOP;
         ex_mem_o.branch_taken <= 1'b0;
      end else if (advance_i && enable_i) begin
         // wrong-path entry dropped while redirecting
         ex_mem_o.valid         <= id_ex_i.valid && !redirect_taken_o;
         ex_mem_o.op            <= id_ex_i.op;
         ex_mem_o.rd            <= id_ex_i.rd;
         ex_mem_o.alu_result    <= alu_result;
         ex_mem_o.store_data    <= rs2_fwd;
         ex_mem_o.branch_taken  <= taken;
         ex_mem_o.branch_target <= id_ex_i.pc + id_ex_i.imm;
      end
   end

endmodule

// ==== hdl/reg_file.sv ====
module reg_file import rv_core_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  reg_addr_t rs1_i,
   input  reg_addr_t rs2_i,
   output word_t     rs1_val_o,
   output word_t     rs2_val_o,
   input  mem_wb_t   wb_i
);

   word_t regs [32];
   logic  wr_en;

   assign wr_en = wb_i.valid && wb_i.we && (wb_i.rd != '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wb_i.rd] <= wb_i.result;
      end
   end

   // x0 reads zero, same-cycle write goes straight through
   always_comb begin
      rs1_val_o = (rs1_i == '0) ? '0 : regs[rs1_i];
      rs2_val_o = (rs2_i == '0) ? '0 : regs[rs2_i];
      if (wr_en && wb_i.rd == rs1_i) begin
         rs1_val_o = wb_i.result;
      end
      if (wr_en && wb_i.rd == rs2_i) begin
         rs2_val_o = wb_i.result;
      end
   end

endmodule

// ==== hdl/decode_stage.sv ====
module decode_stage import rv_core_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      advance_i,
   input  logic      enable_i,
   input  logic      flush_i,
   input  if_id_t    if_id_i,
   output reg_addr_t rs1_o,
   output reg_addr_t rs2_o,
   input  word_t     rs1_val_i,
   input  word_t     rs2_val_i,
   output id_ex_t    id_ex_o
);

   word_t      insn;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   reg_addr_t  rd;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm;
   op_e        op;

   assign insn   = if_id_i.insn;
   assign opcode = insn[6:0];
   assign rd     = insn[11:7];
   assign funct3 = insn[14:12];
   assign rs1_o  = insn[19:15];
   assign rs2_o  = insn[24:20];
   assign funct7 = insn[31:25];

   // sign-extended immediates
   assign imm_i = {{20{insn[31]}}, insn[31:20]};
   assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
   assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

   // anything unsupported becomes a nop
   always_comb begin
      op = OP_NOP;
      case (opcode)
         OPC_OP: begin
            if (funct3 == F3_ADD && funct7 == F7_BASE) begin
               op = OP_ADD;
            end else if (funct3 == F3_ADD && funct7 == F7_SUB) begin
               op = OP_SUB;
            end
         end
         OPC_OP_IMM: op = (funct3 == F3_ADD) ? OP_ADDI : OP_NOP;
         OPC_LOAD:   op = (funct3 == F3_WORD) ? OP_LW : OP_NOP;
         OPC_STORE:  op = (funct3 == F3_WORD) ? OP_SW : OP_NOP;
         OPC_BRANCH: op = (funct3 == F3_BEQ) ? OP_BEQ : OP_NOP;
         default:    op = OP_NOP;
      endcase
   end

   always_comb begin
      case (op)
         OP_SW:   imm = imm_s;
         OP_BEQ:  imm = imm_b;
         default: imm = imm_i;
      endcase
   end

   // ID/EX register, flush turns the slot into a bubble
   always_ff @(posedge clk) begin
      if (reset) begin
         id_ex_o.valid <= 1'b0;
         id_ex_o.op    <= OP_NOP;
      end else if (advance_i && enable_i) begin
         id_ex_o.valid   <= ~flush_i;
         id_ex_o.op      <= flush_i ? OP_NOP : op;
         id_ex_o.pc      <= if_id_i.pc;
         id_ex_o.rd      <= rd;
         id_ex_o.rs1     <= rs1_o;
         id_ex_o.rs2     <= rs2_o;
         id_ex_o.rs1_val <= rs1_val_i;
         id_ex_o.rs2_val <= rs2_val_i;
         id_ex_o.imm     <= imm;
      end
   end

endmodule

// ==== hdl/fetch_stage.sv ====
module fetch_stage import rv_core_pkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  logic   start_i,
   input  word_t  initial_pc_i,
   input  logic   advance_i,
   input  logic   enable_i,
   input  logic   redirect_taken_i,
   input  word_t  redirect_target_i,
   output word_t  imem_addr_o,
   input  word_t  imem_data_i,
   output if_id_t if_id_o
);

   word_t pc;
   logic  step;

   assign step        = advance_i && enable_i;
   assign imem_addr_o = pc;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (start_i) begin
         pc <= initial_pc_i;
      end else if (step) begin
         // taken branch wins over sequential fetch
         pc <= redirect_taken_i ? redirect_target_i : pc + 32'd4;
      end
   end

   // IF/ID register
   always_ff @(posedge clk) begin
      if (reset) begin
         if_id_o.pc   <= '0;
         if_id_o.insn <= NOP_INSN;
      end else if (step) begin
         if_id_o.pc <= pc;
         if (redirect_taken_i) begin
            if_id_o.insn <= NOP_INSN;
         end else begin
            if_id_o.insn <= imem_data_i;
         end
      end
   end

endmodule

// ==== hdl/run_control.sv ====
module run_control import rv_core_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     start_i,
   input  word_t    success_code_i,
   input  mem_req_t periph_write_i,
   input  logic     periph_gnt_i,
   output logic     enable_o,
   output logic     stop_o,
   output word_t    cycle_count_o
);

   run_state_e state;
   word_t      cycle_cnt;
   drain_cnt_t drain_cnt;
   logic       success_hit;

   // granted peripheral store carrying the success code
   assign success_hit = periph_write_i.req && periph_write_i.we && periph_gnt_i &&
                        (periph_write_i.wdata == success_code_i);

   assign enable_o      = (state == RUN_ACTIVE) || (state == RUN_DRAIN);
   assign stop_o        = (state == RUN_STOPPED);
   assign cycle_count_o = cycle_cnt;

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= RUN_IDLE;
         cycle_cnt <= '0;
         drain_cnt <= '0;
      end else begin
         case (state)
            RUN_IDLE: begin
               if (start_i) begin
                  state     <= RUN_ACTIVE;
                  cycle_cnt <= '0;
               end
            end
            RUN_ACTIVE: begin
               cycle_cnt <= cycle_cnt + 32'd1;
               if (success_hit) begin
                  state     <= RUN_DRAIN;
                  drain_cnt <= '0;
               end
            end
            RUN_DRAIN: begin
               cycle_cnt <= cycle_cnt + 32'd1;
               drain_cnt <= drain_cnt + 1'b1;
               if (drain_cnt == DRAIN_LAST) begin
                  state <= RUN_STOPPED;
               end
            end
            // stopped until the next reset
            default: begin
               state <= RUN_STOPPED;
            end
         endcase
      end
   end

endmodule

// ==== hdl/rv_core_pkg.sv ====
package rv_core_pkg;

   // data and address word, register index
   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;

   typedef enum logic [2:0] {
      OP_NOP,
      OP_ADD,
      OP_SUB,
      OP_ADDI,
      OP_LW,
      OP_SW,
      OP_BEQ
   } op_e;

   typedef enum logic [1:0] {
      RUN_IDLE,
      RUN_ACTIVE,
      RUN_DRAIN,
      RUN_STOPPED
   } run_state_e;

   // addresses at or above this go to the peripheral port
   localparam word_t PERIPH_BASE = 32'h8000_0000;
   localparam word_t NOP_INSN    = 32'h0000_0013;

   // drain length after the success store
   localparam int unsigned DRAIN_CYCLES = 30;
   localparam int unsigned DRAIN_CNT_W  = $clog2(DRAIN_CYCLES);
   typedef logic [DRAIN_CNT_W-1:0] drain_cnt_t;
   localparam drain_cnt_t DRAIN_LAST = drain_cnt_t'(DRAIN_CYCLES - 1);

   // rv32i major opcodes and function codes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [2:0] F3_ADD     = 3'b000;
   localparam logic [2:0] F3_WORD    = 3'b010;
   localparam logic [2:0] F3_BEQ     = 3'b000;
   localparam logic [6:0] F7_BASE    = 7'b0000000;
   localparam logic [6:0] F7_SUB     = 7'b0100000;

   typedef struct packed {
      word_t pc;
      word_t insn;
   } if_id_t;

   typedef struct packed {
      logic      valid;
      op_e       op;
      word_t     pc;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      word_t     rs1_val;
      word_t     rs2_val;
      word_t     imm;
   } id_ex_t;

   typedef struct packed {
      logic      valid;
      op_e       op;
      reg_addr_t rd;
      word_t     alu_result;
      word_t     store_data;
      logic      branch_taken;
      word_t     branch_target;
   } ex_mem_t;

   typedef struct packed {
      logic      valid;
      logic      we;
      reg_addr_t rd;
      word_t     result;
   } mem_wb_t;

   typedef struct packed {
      logic  req;
      logic  we;
      word_t addr;
      word_t wdata;
   } mem_req_t;

   typedef struct packed {
      logic  gnt;
      word_t rdata;
   } mem_rsp_t;

   typedef struct packed {
      logic      valid;
      reg_addr_t rd;
      word_t     value;
   } fwd_t;

endpackage
